//--- sim.f
+incdir+.
norm_check_pkg.sv
norm_check_unit.sv
norm_check_ctrl.sv
norm_check_core.sv
norm_check_regs.sv
coeff_mem.sv
norm_check_subsystem.sv
norm_check_tb.sv

//--- Makefile
# Verilator flow for the norm-check subsystem
# Any variable can be overridden on the command line, e.g. make sim TOP=norm_check_tb

VERILATOR ?= verilator
TOP       ?= norm_check_tb
SEED_ARGS ?= +verilator+seed+1
BUILD_DIR ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

# Static checks over every source in the file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# Build and run; a $$fatal in the testbench makes the binary, and so make, fail
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) $(SEED_ARGS)

clean:
	rm -rf $(BUILD_DIR)

//--- norm_check_tb.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_tb;

    localparam int unsigned Q        = `NC_Q;
    localparam int unsigned N_COEFF  = (1 << `NC_MEM_ADDR_W) * `NC_LANES;
    localparam int unsigned N_WORDS  = 1 << `NC_MEM_ADDR_W;
    // Budget of 40 runs, each at most 512 read cycles plus 200 cycles of bus traffic
    localparam longint      WATCHDOG_NS = 40 * (512 + 200) * 40;

    logic                    clk;
    logic                    reset_n;
    norm_check_pkg::wb_req_t wb_req;
    norm_check_pkg::wb_rsp_t wb_rsp;
    logic                    done_irq;

    // Shadow copy of every coefficient the host has written
    logic [`NC_COEFF_W-1:0]  shadow [0:N_COEFF-1];

    // Number of clock cycles the interrupt line has been seen high
    int unsigned             irq_count;
    int unsigned             irq_at_start;

    norm_check_subsystem dut (
        .clk      (clk),
        .reset_n  (reset_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .done_irq (done_irq)
    );

    // 40 ns clock period
    always #20 clk = ~clk;

    // Sampled mid-cycle where the registered interrupt is stable
    always @(negedge clk) begin
        if (done_irq)
            irq_count <= irq_count + 1;
    end

    task automatic stop_run(input string what);
        $display("Run stopped: %s", what);
        $display("TESTS FAILED");
        $fatal(1, "%s", what);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else begin
            $display("** Error [%s]: expected %0h, actual %0h", name, expected, actual);
            stop_run("a checked value did not match");
        end
    endtask

    // Bound of each mode from the scheme parameters
    function automatic int unsigned mode_bound(input int unsigned mode);
        case (mode)
            0:       return `NC_GAMMA1 - `NC_BETA;
            1:       return `NC_GAMMA2 - `NC_BETA;
            default: return `NC_GAMMA2;
        endcase
    endfunction

    // The upper half of [0, q) stands for negative values and maps to q - c
    function automatic bit coeff_violates(input int unsigned c, input int unsigned mode);
        int unsigned mag;
        mag = (c <= (Q - 1) / 2) ? c : Q - c;
        return (c >= Q) || (mag >= mode_bound(mode));
    endfunction

    // Expected sticky flag over npoly x 64 words, wrapping at the top of memory
    function automatic bit model_invalid(input int unsigned mode, input int unsigned base,
                                         input int unsigned npoly);
        int unsigned addr;
        bit          flag;
        flag = 1'b0;
        for (int unsigned w = 0; w < npoly * `NC_WORDS_PER_POLY; w++) begin
            addr = (base + w) % N_WORDS;
            for (int unsigned l = 0; l < `NC_LANES; l++)
                flag = flag | coeff_violates(shadow[addr * `NC_LANES + l], mode);
        end
        return flag;
    endfunction

    // Magnitude below the tightest bound, so legal in every mode
    function automatic logic [`NC_COEFF_W-1:0] random_in_range();
        int unsigned r;
        r = $urandom % (`NC_GAMMA2 - `NC_BETA);
        if (($urandom % 2) == 1 && r != 0)
            return `NC_COEFF_W'(Q - r);
        return `NC_COEFF_W'(r);
    endfunction

    // One classic Wishbone cycle is driven 2 ns after the edge
    // The request stays up through the edge at which the slave's ack is sampled
    task automatic bus_cycle(input logic we, input logic [11:0] adr,
                             input logic [31:0] wdata, output logic [31:0] rdata);
        int waited;
        @(posedge clk);
        #2;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = we;
        wb_req.adr   = adr;
        wb_req.dat_w = wdata;
        waited = 0;
        do begin
            @(posedge clk);
            #1;
            waited++;
            if (waited > 20)
                stop_run("no Wishbone ack within 20 cycles");
        end while (!wb_rsp.ack);
        rdata = wb_rsp.dat_r;
        @(posedge clk);
        #2;
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we  = 1'b0;
    endtask

    task automatic reg_write(input int unsigned word, input int unsigned data);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, 12'(word), data, unused_rd);
    endtask

    task automatic reg_read(input int unsigned word, output logic [31:0] data);
        bus_cycle(1'b0, 12'(word), 32'd0, data);
    endtask

    // Window write; the shadow follows only when the DUT is expected to take it
    task automatic plant_coeff(input int unsigned idx, input int unsigned value, input bit track);
        logic [31:0] unused_rd;
        bus_cycle(1'b1, 12'(N_COEFF + idx), value, unused_rd);
        if (track)
            shadow[idx] = `NC_COEFF_W'(value);
    endtask

    task automatic start_run(input int unsigned mode, input int unsigned base,
                             input int unsigned npoly);
        irq_at_start = irq_count;
        reg_write(1, base);
        reg_write(2, npoly);
        reg_write(0, (mode << 1) | 1);
    endtask

    // Poll STATUS until ready, then compare the whole word with the model
    // Each finished run raises the interrupt for exactly one cycle
    task automatic finish_run(input string name, input int unsigned mode,
                              input int unsigned base, input int unsigned npoly);
        logic [31:0] status;
        int          polls;
        bit          expected;
        polls = 0;
        do begin
            reg_read(3, status);
            polls++;
            if (polls > 1000)
                stop_run("STATUS ready never rose after a start");
        end while (!status[1]);
        expected = model_invalid(mode, base, npoly);
        check_value(name, {29'd0, expected, 2'b10}, status);
        check_value({name, "_irq"}, 32'd1, irq_count - irq_at_start);
    endtask

    task automatic run_vector(input string name, input int unsigned mode,
                              input int unsigned base, input int unsigned npoly);
        start_run(mode, base, npoly);
        finish_run(name, mode, base, npoly);
    endtask

    // Ends the run if it takes longer than the budget
    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        $display("TESTS FAILED");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        int unsigned base;
        int unsigned npoly;
        int unsigned mode;
        int unsigned idx;
        int unsigned old;
        int unsigned b;
        int unsigned edge_val [4];
        int          offs [4];
        logic [31:0] rd;

        clk     = 1'b0;
        reset_n = 1'b0;
        wb_req  = '0;
        void'($urandom(32'h843));

        repeat (8) @(posedge clk);
        #1;
        check_value("reset ack", 32'd0, {31'd0, wb_rsp.ack});
        #1 reset_n = 1'b1;
        reg_read(3, rd);
        check_value("reset status", 32'd0, rd);

        // Whole memory starts legal in every mode
        for (int unsigned i = 0; i < N_COEFF; i++)
            plant_coeff(i, random_in_range(), 1'b1);

        // 1. Legal vectors at random places and lengths
        for (int unsigned m = 0; m < 3; m++) begin
            repeat (2) run_vector("in_range", m, $urandom % N_WORDS, 1 + $urandom % 8);
        end

        // 2. One coefficient on either side of each edge of the bound
        for (int unsigned m = 0; m < 3; m++) begin
            b = mode_bound(m);
            edge_val = '{b - 1, b, Q - b, Q - b + 1};
            for (int k = 0; k < 4; k++) begin
                base  = $urandom % N_WORDS;
                npoly = 1 + $urandom % 8;
                idx   = ((base + $urandom % (npoly * 64)) % N_WORDS) * 4 + $urandom % 4;
                old   = shadow[idx];
                plant_coeff(idx, edge_val[k], 1'b1);
                run_vector("bound_edge", m, base, npoly);
                plant_coeff(idx, old, 1'b1);
            end
        end
        // The r0 bound itself is legal for z but not for r0
        idx = $urandom % N_COEFF;
        old = shadow[idx];
        plant_coeff(idx, mode_bound(1), 1'b1);
        run_vector("mode_split_z", 0, idx / 4, 1);
        run_vector("mode_split_r0", 1, idx / 4, 1);
        plant_coeff(idx, old, 1'b1);

        // 3. Neighbours of the vector are ignored, its ends are not
        base  = $urandom % N_WORDS;
        npoly = 1 + $urandom % 7;
        offs  = '{-1, npoly * 64, 0, npoly * 64 - 1};
        for (int k = 0; k < 4; k++) begin
            idx = ((base + N_WORDS + offs[k]) % N_WORDS) * 4 + $urandom % 4;
            old = shadow[idx];
            plant_coeff(idx, `NC_GAMMA1, 1'b1);
            run_vector("vector_range", 0, base, npoly);
            plant_coeff(idx, old, 1'b1);
        end

        // 4. Register readback and NPOLY clamp
        base = $urandom % N_WORDS;
        reg_write(1, base);
        reg_read(1, rd);
        check_value("base_readback", base, rd);
        reg_write(2, 0);
        reg_read(2, rd);
        check_value("npoly_clamp_low", 1, rd);
        reg_write(2, 12);
        reg_read(2, rd);
        check_value("npoly_clamp_high", 8, rd);
        reg_write(2, 5);
        reg_read(2, rd);
        check_value("npoly_readback", 5, rd);
        reg_write(0, 2 << 1);
        reg_read(0, rd);
        check_value("mode_readback", 2 << 1, rd);
        // A window write mid-run must be dropped, so the shadow stays as is
        mode = 1;
        start_run(mode, base, 8);
        reg_read(3, rd);
        check_value("busy_during_run", 1, {31'd0, rd[0]});
        plant_coeff(base * 4, `NC_GAMMA1, 1'b0);
        finish_run("write_while_busy", mode, base, 8);
        run_vector("rerun_after_drop", mode, base, 8);

        // 5. Zeroize clears a finished result and aborts a live run
        idx = $urandom % N_COEFF;
        old = shadow[idx];
        plant_coeff(idx, `NC_GAMMA1, 1'b1);
        run_vector("zeroize_setup", 0, base, 8);
        reg_write(0, 8);
        reg_read(3, rd);
        check_value("zeroize_after_done", 0, rd);
        start_run(0, base, 8);
        reg_read(3, rd);
        check_value("busy_before_abort", 1, {31'd0, rd[0]});
        reg_write(0, 8);
        reg_read(3, rd);
        check_value("zeroize_abort", 0, rd);
        // Long enough for the aborted run to have finished had it kept going
        repeat (8 * 64 + 10) @(posedge clk);
        reg_read(3, rd);
        check_value("no_late_ready", 0, rd);
        check_value("no_late_irq", irq_at_start, irq_count);
        run_vector("after_zeroize", 0, base, 8);
        plant_coeff(idx, old, 1'b1);

        // 6. Invalid run followed by a clean one
        mode  = $urandom % 3;
        base  = $urandom % N_WORDS;
        npoly = 1 + $urandom % 8;
        idx   = base * 4 + $urandom % 4;
        old   = shadow[idx];
        plant_coeff(idx, `NC_GAMMA1, 1'b1);
        run_vector("back_to_back_bad", mode, base, npoly);
        plant_coeff(idx, old, 1'b1);
        run_vector("back_to_back_good", mode, base, npoly);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- norm_check_subsystem.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_subsystem (
    input  logic                    clk,
    input  logic                    reset_n,
    input  norm_check_pkg::wb_req_t wb_req,
    output norm_check_pkg::wb_rsp_t wb_rsp,
    output logic                    done_irq
);

    norm_check_pkg::nc_cmd_t              cmd;
    norm_check_pkg::mem_wr_req_t          mem_wr;
    norm_check_pkg::mem_rd_req_t          mem_rd_req;
    logic [`NC_LANES*`NC_COEFF_W-1:0]     mem_rd_data;
    logic                                 invalid;
    logic                                 norm_check_done;
    logic                                 norm_check_ready;

    // Bus side with registers and the coefficient window
    norm_check_regs regs_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .wb_req          (wb_req),
        .wb_rsp          (wb_rsp),
        .cmd             (cmd),
        .mem_wr          (mem_wr),
        .invalid         (invalid),
        .norm_check_done (norm_check_done)
    );

    // Host writes in one port and the core reads out the other
    coeff_mem mem_inst (
        .clk        (clk),
        .mem_wr     (mem_wr),
        .mem_rd_req (mem_rd_req),
        .rd_data    (mem_rd_data)
    );

    norm_check_core core_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (cmd.zeroize),
        .start            (cmd.start),
        .mode             (cmd.mode),
        .base             (cmd.base),
        .npoly            (cmd.npoly),
        .mem_rd_req       (mem_rd_req),
        .mem_rd_data      (mem_rd_data),
        .invalid          (invalid),
        .norm_check_ready (norm_check_ready),
        .norm_check_done  (norm_check_done)
    );

    // Interrupt is the ready pulse so a host need not poll STATUS
    assign done_irq = norm_check_ready;

endmodule

`default_nettype wire

//--- coeff_mem.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module coeff_mem (
    input  logic                                 clk,
    input  norm_check_pkg::mem_wr_req_t          mem_wr,
    input  norm_check_pkg::mem_rd_req_t          mem_rd_req,
    output logic [`NC_LANES*`NC_COEFF_W-1:0]     rd_data
);

    localparam int DEPTH  = 1 << `NC_MEM_ADDR_W;
    localparam int LANE_W = $clog2(`NC_LANES);

    // Each word is an array of lanes so a single lane can be written
    logic [`NC_LANES-1:0][`NC_COEFF_W-1:0] mem [0:DEPTH-1];

    logic [`NC_MEM_ADDR_W-1:0] wr_word;
    logic [LANE_W-1:0]         wr_lane;

    // Coefficient index splits into word and lane
    assign wr_word = mem_wr.idx[LANE_W +: `NC_MEM_ADDR_W];
    assign wr_lane = mem_wr.idx[LANE_W-1:0];

    // Host write port touches one lane of one word
    always_ff @(posedge clk) begin
        if (mem_wr.wr_en)
            mem[wr_word][wr_lane] <= mem_wr.data;
    end

    // Registered read with one cycle of latency
    // Output holds its last value when no read is issued
    always_ff @(posedge clk) begin
        if (mem_rd_req.rd_en)
            rd_data <= mem[mem_rd_req.addr];
    end

endmodule

`default_nettype wire

//--- norm_check_regs.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_regs (
    input  logic                          clk,
    input  logic                          reset_n,
    input  norm_check_pkg::wb_req_t       wb_req,
    output norm_check_pkg::wb_rsp_t       wb_rsp,
    output norm_check_pkg::nc_cmd_t       cmd,
    output norm_check_pkg::mem_wr_req_t   mem_wr,
    input  logic                          invalid,
    input  logic                          norm_check_done
);

    localparam int REG_W = `NC_WB_ADR_W - 1;
    localparam int IDX_W = `NC_MEM_ADDR_W + 2;

    logic                           ack_q;
    logic [`NC_WB_DAT_W-1:0]        dat_r_q;
    logic [`NC_WB_DAT_W-1:0]        rd_mux;
    logic                           acc;
    logic                           win_sel;
    logic [REG_W-1:0]               reg_word;
    logic                           ctrl_wr;
    logic                           zero_req;
    logic                           start_req;
    logic [3:0]                     npoly_wr;
    norm_check_pkg::chk_norm_mode_t mode_q;
    logic [`NC_MEM_ADDR_W-1:0]      base_q;
    logic [3:0]                     npoly_q;
    logic                           busy_q;
    logic                           ready_q;
    logic                           invalid_q;
    logic                           start_q;
    logic                           zeroize_q;
    logic                           wr_en_q;
    logic [IDX_W-1:0]               wr_idx_q;
    logic [`NC_COEFF_W-1:0]         wr_data_q;

    // A cycle is served once and the ack itself blocks a second service
    assign acc       = wb_req.cyc && wb_req.stb && !ack_q;
    assign win_sel   = wb_req.adr[`NC_WB_ADR_W-1];
    assign reg_word  = wb_req.adr[REG_W-1:0];
    assign ctrl_wr   = acc && wb_req.we && !win_sel && (reg_word == '0);
    assign zero_req  = ctrl_wr && wb_req.dat_w[3];
    // Zeroize in the same write overrides start
    assign start_req = ctrl_wr && wb_req.dat_w[0] && !wb_req.dat_w[3] && !busy_q;

    // NPOLY writes are clamped into 1 to 8
    always_comb begin
        if (wb_req.dat_w == '0)
            npoly_wr = 4'd1;
        else if (wb_req.dat_w > `NC_WB_DAT_W'(`NC_MAX_POLY))
            npoly_wr = 4'(`NC_MAX_POLY);
        else
            npoly_wr = wb_req.dat_w[3:0];
    end

    // Window reads and unmapped words return zero
    always_comb begin
        rd_mux = '0;
        if (!win_sel) begin
            case (reg_word)
                REG_W'(0): rd_mux[2:1] = mode_q;
                REG_W'(1): rd_mux[`NC_MEM_ADDR_W-1:0] = base_q;
                REG_W'(2): rd_mux[3:0] = npoly_q;
                REG_W'(3): rd_mux[2:0] = {invalid_q, ready_q, busy_q};
                default:   rd_mux = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            ack_q     <= 1'b0;
            start_q   <= 1'b0;
            zeroize_q <= 1'b0;
            wr_en_q   <= 1'b0;
            busy_q    <= 1'b0;
            ready_q   <= 1'b0;
            invalid_q <= 1'b0;
            mode_q    <= norm_check_pkg::CHK_Z;
            base_q    <= '0;
            npoly_q   <= 4'd1;
        end else begin
            ack_q     <= acc;
            start_q   <= start_req;
            zeroize_q <= zero_req;
            // Memory is frozen for the duration of a run
            wr_en_q   <= acc && wb_req.we && win_sel && !busy_q;
            if (zero_req) begin
                busy_q    <= 1'b0;
                ready_q   <= 1'b0;
                invalid_q <= 1'b0;
            end else if (start_req) begin
                busy_q    <= 1'b1;
                ready_q   <= 1'b0;
                invalid_q <= 1'b0;
            end else if (norm_check_done && !zeroize_q) begin
                // The core can still finish in the cycle the abort reaches it
                busy_q    <= 1'b0;
                ready_q   <= 1'b1;
                invalid_q <= invalid;
            end
            // Run parameters stay fixed while busy
            if (ctrl_wr && !busy_q)
                mode_q <= norm_check_pkg::chk_norm_mode_t'(wb_req.dat_w[2:1]);
            if (acc && wb_req.we && !win_sel && (reg_word == REG_W'(1)) && !busy_q)
                base_q <= wb_req.dat_w[`NC_MEM_ADDR_W-1:0];
            if (acc && wb_req.we && !win_sel && (reg_word == REG_W'(2)) && !busy_q)
                npoly_q <= npoly_wr;
        end
    end

    always_ff @(posedge clk) begin
        if (acc) begin
            dat_r_q   <= rd_mux;
            wr_idx_q  <= wb_req.adr[IDX_W-1:0];
            wr_data_q <= wb_req.dat_w[`NC_COEFF_W-1:0];
        end
    end

    assign wb_rsp.ack   = ack_q;
    assign wb_rsp.dat_r = dat_r_q;

    assign cmd.start   = start_q;
    assign cmd.zeroize = zeroize_q;
    assign cmd.mode    = mode_q;
    assign cmd.base    = base_q;
    assign cmd.npoly   = npoly_q;

    assign mem_wr.wr_en = wr_en_q;
    assign mem_wr.idx   = wr_idx_q;
    assign mem_wr.data  = wr_data_q;

    // Ack only answers a cycle the master is still holding
    a_ack_held: assert property (@(posedge clk) disable iff (!reset_n)
        wb_rsp.ack |-> wb_req.cyc && wb_req.stb);

    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        wb_rsp.ack |=> !wb_rsp.ack);

endmodule

`default_nettype wire

//--- norm_check_core.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_core (
    input  logic                                 clk,
    input  logic                                 reset_n,
    input  logic                                 zeroize,
    input  logic                                 start,
    input  norm_check_pkg::chk_norm_mode_t       mode,
    input  logic [`NC_MEM_ADDR_W-1:0]            base,
    input  logic [3:0]                           npoly,
    output norm_check_pkg::mem_rd_req_t          mem_rd_req,
    input  logic [`NC_LANES*`NC_COEFF_W-1:0]     mem_rd_data,
    output logic                                 invalid,
    output logic                                 norm_check_ready,
    output logic                                 norm_check_done
);

    logic                 check_enable;
    logic                 check_enable_q;
    logic [`NC_LANES-1:0] lane_invalid;

    norm_check_ctrl ctrl_inst (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize         (zeroize),
        .start           (start),
        .base            (base),
        .npoly           (npoly),
        .mem_rd_req      (mem_rd_req),
        .check_enable    (check_enable),
        .norm_check_done (norm_check_done)
    );

    // One check unit per lane of the returned word
    for (genvar i = 0; i < `NC_LANES; i++) begin : g_lane
        norm_check_unit unit_inst (
            .enable  (check_enable_q),
            .mode    (mode),
            .coeff   (mem_rd_data[i*`NC_COEFF_W +: `NC_COEFF_W]),
            .invalid (lane_invalid[i])
        );
    end

    // Sticky flag collects every lane over the whole vector
    // It is consumed by the register block in the done cycle and cleared right after
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n)
            invalid <= 1'b0;
        else if (zeroize || norm_check_done)
            invalid <= 1'b0;
        else
            invalid <= invalid | (|lane_invalid);
    end

    // Enable delay matches the memory read latency
    // Ready trails done by a cycle to leave time for capturing the flag
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            check_enable_q   <= 1'b0;
            norm_check_ready <= 1'b0;
        end else if (zeroize) begin
            check_enable_q   <= 1'b0;
            norm_check_ready <= 1'b0;
        end else begin
            check_enable_q   <= check_enable;
            norm_check_ready <= norm_check_done;
        end
    end

    // A new vector always starts from a clean flag
    a_flag_clear: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done |=> !invalid);

endmodule

`default_nettype wire

//--- norm_check_ctrl.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_ctrl (
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          zeroize,
    input  logic                          start,
    input  logic [`NC_MEM_ADDR_W-1:0]     base,
    input  logic [3:0]                    npoly,
    output norm_check_pkg::mem_rd_req_t   mem_rd_req,
    output logic                          check_enable,
    output logic                          norm_check_done
);

    // One extra bit so a full 512-word vector can be counted
    localparam int CNT_W = `NC_MEM_ADDR_W + 1;

    norm_check_pkg::ctrl_state_t state;
    norm_check_pkg::ctrl_state_t state_nxt;
    logic [CNT_W-1:0]            word_cnt;
    logic [CNT_W-1:0]            word_total;
    logic                        last_read;

    assign word_total = CNT_W'(npoly) * CNT_W'(`NC_WORDS_PER_POLY);
    assign last_read  = (word_cnt == word_total - 1'b1);

    always_comb begin
        state_nxt = state;
        case (state)
            norm_check_pkg::IDLE:   if (start) state_nxt = norm_check_pkg::READ;
            norm_check_pkg::READ:   if (last_read) state_nxt = norm_check_pkg::DRAIN;
            // Last word is in the memory output register
            norm_check_pkg::DRAIN:  state_nxt = norm_check_pkg::FINISH;
            // Flag holds every lane result in this cycle
            norm_check_pkg::FINISH: state_nxt = norm_check_pkg::IDLE;
            default:                state_nxt = norm_check_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= norm_check_pkg::IDLE;
            word_cnt <= '0;
        end else if (zeroize) begin
            state    <= norm_check_pkg::IDLE;
            word_cnt <= '0;
        end else begin
            state <= state_nxt;
            // Counter advances once per issued read and rests at zero otherwise
            if (state == norm_check_pkg::READ)
                word_cnt <= word_cnt + 1'b1;
            else
                word_cnt <= '0;
        end
    end

    // Address wraps at the top of the memory
    assign mem_rd_req.rd_en = (state == norm_check_pkg::READ);
    assign mem_rd_req.addr  = base + word_cnt[`NC_MEM_ADDR_W-1:0];

    // Marks the cycles whose data the core must check one cycle later
    assign check_enable    = (state == norm_check_pkg::READ);
    assign norm_check_done = (state == norm_check_pkg::FINISH);

    // No memory traffic while idle
    a_no_read_idle: assert property (@(posedge clk) disable iff (!reset_n)
        (state == norm_check_pkg::IDLE) |-> !mem_rd_req.rd_en);

    a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n)
        norm_check_done |=> !norm_check_done);

endmodule

`default_nettype wire

//--- norm_check_unit.sv
`timescale 1ns/1ps
`default_nettype none
`include "norm_check_config.svh"

module norm_check_unit (
    input  logic                        enable,
    input  norm_check_pkg::chk_norm_mode_t mode,
    input  logic [`NC_COEFF_W-1:0]      coeff,
    output logic                        invalid
);

    localparam logic [`NC_COEFF_W-1:0] Q    = `NC_COEFF_W'(`NC_Q);
    localparam logic [`NC_COEFF_W-1:0] HALF = `NC_COEFF_W'((`NC_Q - 1) / 2);

    logic [`NC_COEFF_W-1:0] centered;
    logic [`NC_COEFF_W-1:0] bound;
    logic                   out_of_range;

    // Coefficients above (q-1)/2 stand for negative values
    // Their magnitude is the distance up to q
    assign centered = (coeff <= HALF) ? coeff : (Q - coeff);

    // A value of q or more is not a reduced coefficient at all
    assign out_of_range = (coeff >= Q);

    always_comb begin
        case (mode)
            norm_check_pkg::CHK_Z:   bound = `NC_COEFF_W'(`NC_GAMMA1 - `NC_BETA);
            norm_check_pkg::CHK_R0:  bound = `NC_COEFF_W'(`NC_GAMMA2 - `NC_BETA);
            norm_check_pkg::CHK_CT0: bound = `NC_COEFF_W'(`NC_GAMMA2);
            // The unused encoding falls back to the tightest bound
            default:                 bound = `NC_COEFF_W'(`NC_GAMMA2 - `NC_BETA);
        endcase
    end

    // Reaching the bound already counts as a violation
    assign invalid = enable && (out_of_range || (centered >= bound));

endmodule

`default_nettype wire

//--- norm_check_pkg.sv
`default_nettype none
`include "norm_check_config.svh"

package norm_check_pkg;

    // Selects which bound the check units apply
    typedef enum logic [1:0] {
        CHK_Z   = 2'd0,
        CHK_R0  = 2'd1,
        CHK_CT0 = 2'd2
    } chk_norm_mode_t;

    // States of the read sequencer
    typedef enum logic [1:0] {
        IDLE   = 2'd0,
        READ   = 2'd1,
        DRAIN  = 2'd2,
        FINISH = 2'd3
    } ctrl_state_t;

    // Read request toward the coefficient memory
    typedef struct packed {
        logic                      rd_en;
        logic [`NC_MEM_ADDR_W-1:0] addr;
    } mem_rd_req_t;

    // Single-lane write where idx is the coefficient index (word and lane)
    typedef struct packed {
        logic                        wr_en;
        logic [`NC_MEM_ADDR_W+1:0]   idx;
        logic [`NC_COEFF_W-1:0]      data;
    } mem_wr_req_t;

    typedef struct packed {
        logic                    cyc;
        logic                    stb;
        logic                    we;
        logic [`NC_WB_ADR_W-1:0] adr;
        logic [`NC_WB_DAT_W-1:0] dat_w;
    } wb_req_t;

    typedef struct packed {
        logic                    ack;
        logic [`NC_WB_DAT_W-1:0] dat_r;
    } wb_rsp_t;

    // Command bundle from the register block to the core
    typedef struct packed {
        logic                      start;
        logic                      zeroize;
        chk_norm_mode_t            mode;
        logic [`NC_MEM_ADDR_W-1:0] base;
        logic [3:0]                npoly;
    } nc_cmd_t;

endpackage

`default_nettype wire

//--- norm_check_config.svh
`ifndef NORM_CHECK_CONFIG_SVH
`define NORM_CHECK_CONFIG_SVH

// Prime modulus of the coefficient ring
`define NC_Q              8380417

// Range parameters of the signature scheme
`define NC_GAMMA1         524288
`define NC_GAMMA2         261888
`define NC_BETA           120

// Each memory word packs four coefficient lanes
`define NC_COEFF_W        24
`define NC_LANES          4

// One polynomial of 256 coefficients fills 64 words
`define NC_WORDS_PER_POLY 64

// 512 words of coefficient storage
`define NC_MEM_ADDR_W     9
`define NC_MAX_POLY       8

// Wishbone word address and data widths
`define NC_WB_ADR_W       12
`define NC_WB_DAT_W       32

`endif
